//--- rtl/rf_pkg.sv
// Shared definitions for the register-file subsystem
//   Maximum port field widths
//   Write-port request struct
//   Read-port struct, address in and data out
//   Clear sequencer state encoding

`default_nettype none

package rf_pkg;

  // -------------------------------------------------------------------------
  // Field widths
  // -------------------------------------------------------------------------

  // Upper bounds for the top-level ADDR_WIDTH and DATA_WIDTH
  localparam int unsigned ADDR_W_MAX = 5;
  localparam int unsigned DATA_W_MAX = 32;

  // -------------------------------------------------------------------------
  // Port structs
  // -------------------------------------------------------------------------

  // One write port request
  // Only the low ADDR_WIDTH / DATA_WIDTH bits are used by the modules
  typedef struct packed {
    logic                  we;
    logic [ADDR_W_MAX-1:0] addr;
    logic [DATA_W_MAX-1:0] data;
  } rf_wr_t;

  // One read port
  // Address travels into the storage, data comes back
  typedef struct packed {
    logic [ADDR_W_MAX-1:0] addr;
    logic [DATA_W_MAX-1:0] data;
  } rf_rd_t;

  // -------------------------------------------------------------------------
  // Clear sequencer
  // -------------------------------------------------------------------------

  // Idle, or zeroing one word pair per cycle
  typedef enum logic {
    CLR_IDLE = 1'b0,
    CLR_RUN  = 1'b1
  } clr_state_e;

endpackage

`default_nettype wire

//--- rtl/rf_addr_counter.sv
// Address counter for the bulk-clear sequence
//   Walks even word-pair base addresses from zero
//   Flags the final pair combinationally

`timescale 1ns/100ps
`default_nettype none

module rf_addr_counter #(
  parameter int unsigned ADDR_WIDTH = 5
) (
  input  logic                  clk_int,
  input  logic                  rst_n,
  input  logic                  start_i,
  input  logic                  en_i,
  output logic [ADDR_WIDTH-1:0] addr_o,
  output logic                  last_o
);

  // Base address of the highest word pair, all ones with bit 0 clear
  localparam logic [ADDR_WIDTH-1:0] LAST_PAIR = {{(ADDR_WIDTH-1){1'b1}}, 1'b0};

  logic [ADDR_WIDTH-1:0] addr_q;

  // Start wins over advance
  always_ff @(posedge clk_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      addr_q <= '0;
    end
    else if (start_i)
    begin
      addr_q <= '0;
    end
    else if (en_i)
    begin
      // Step to the next pair, wraps to zero after the last one
      addr_q <= addr_q + ADDR_WIDTH'(2);
    end
  end

  assign addr_o = addr_q;
  assign last_o = (addr_q == LAST_PAIR);

  // Pair base must stay even, the arbiter derives the odd word from it
  a_addr_even : assert property (@(posedge clk_int) disable iff (!rst_n)
    addr_o[0] == 1'b0)
    else $error("rf_addr_counter: odd pair base address %0d", addr_o);

endmodule

`default_nettype wire

//--- rtl/rf_clear_fsm.sv
// Bulk-clear state machine
//   Accepts a clear request while idle
//   Starts and steps the pair address counter
//   Holds the clearing level until the last pair is written

`timescale 1ns/100ps
`default_nettype none

module rf_clear_fsm (
  input  logic clk_int,
  input  logic rst_n,
  input  logic clear_i,
  input  logic cnt_last_i,
  output logic cnt_start_o,
  output logic cnt_en_o,
  output logic clearing_o
);

  import rf_pkg::*;

  clr_state_e state_q;
  clr_state_e state_d;

  // -------------------------------------------------------------------------
  // Next state
  // -------------------------------------------------------------------------

  always_comb
  begin
    state_d     = state_q;
    cnt_start_o = 1'b0;
    case (state_q)
      CLR_IDLE:
      begin
        // Request accepted, counter loads pair zero at the same edge
        if (clear_i)
        begin
          state_d     = CLR_RUN;
          cnt_start_o = 1'b1;
        end
      end
      CLR_RUN:
      begin
        // Requests are ignored here
        // Leave after the final pair has been written
        if (cnt_last_i)
        begin
          state_d = CLR_IDLE;
        end
      end
      default:
      begin
        state_d = CLR_IDLE;
      end
    endcase
  end

  // -------------------------------------------------------------------------
  // State register
  // -------------------------------------------------------------------------

  always_ff @(posedge clk_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= CLR_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Busy level and counter step, both tied to the run state
  assign clearing_o = (state_q == CLR_RUN);
  assign cnt_en_o   = (state_q == CLR_RUN);

  // A second clear while running must not restart the counter
  a_no_start_in_run : assert property (@(posedge clk_int) disable iff (!rst_n)
    (state_q == CLR_RUN) |-> !cnt_start_o)
    else $error("rf_clear_fsm: counter restarted during a clear");

endmodule

`default_nettype wire

//--- rtl/rf_write_arbiter.sv
// Write-port arbiter
//   Pair-zeroing writes while a clear runs
//   External writes pass through otherwise
//   External strobes are dropped during a clear

`timescale 1ns/100ps
`default_nettype none

module rf_write_arbiter #(
  parameter int unsigned ADDR_WIDTH = 5
) (
  input  logic                  clearing_i,
  input  logic [ADDR_WIDTH-1:0] cnt_addr_i,
  input  rf_pkg::rf_wr_t        wr_a_i,
  input  rf_pkg::rf_wr_t        wr_b_i,
  output rf_pkg::rf_wr_t        wr_a_o,
  output rf_pkg::rf_wr_t        wr_b_o
);

  import rf_pkg::*;

  // Clear addresses widened to the struct field
  logic [ADDR_W_MAX-1:0] clr_addr_a;
  logic [ADDR_W_MAX-1:0] clr_addr_b;

  // Port A takes the even word, port B the odd word above it
  always_comb
  begin
    clr_addr_a                   = '0;
    clr_addr_b                   = '0;
    clr_addr_a[ADDR_WIDTH-1:0]   = cnt_addr_i;
    clr_addr_b[ADDR_WIDTH-1:0]   = cnt_addr_i + ADDR_WIDTH'(1);
  end

  always_comb
  begin
    if (clearing_i)
    begin
      // External requests are lost here, no back-pressure
      wr_a_o.we   = 1'b1;
      wr_a_o.addr = clr_addr_a;
      wr_a_o.data = '0;
      wr_b_o.we   = 1'b1;
      wr_b_o.addr = clr_addr_b;
      wr_b_o.data = '0;
    end
    else
    begin
      wr_a_o = wr_a_i;
      wr_b_o = wr_b_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rf_storage.sv
// Register-file storage
//   Flip-flop words, word 0 hardwired to zero
//   One-hot write decode per port, port B wins on a shared word
//   Three combinational read ports
//   Width checks at elaboration

`timescale 1ns/100ps
`default_nettype none

module rf_storage #(
  parameter int unsigned ADDR_WIDTH = 5,
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic           clk_int,
  input  logic           rst_n,
  input  rf_pkg::rf_wr_t wr_a_i,
  input  rf_pkg::rf_wr_t wr_b_i,
  input  rf_pkg::rf_rd_t rd_a_i,
  input  rf_pkg::rf_rd_t rd_b_i,
  input  rf_pkg::rf_rd_t rd_c_i,
  output rf_pkg::rf_rd_t rd_a_o,
  output rf_pkg::rf_rd_t rd_b_o,
  output rf_pkg::rf_rd_t rd_c_o
);

  import rf_pkg::*;

  localparam int unsigned NUM_WORDS = 2 ** ADDR_WIDTH;

  // Fields must fit the package structs, and a clear needs at least two pairs
  if (ADDR_WIDTH < 2 || ADDR_WIDTH > ADDR_W_MAX || DATA_WIDTH > DATA_W_MAX)
  begin : g_width_check
    $error("rf_storage: ADDR_WIDTH %0d / DATA_WIDTH %0d not supported",
           ADDR_WIDTH, DATA_WIDTH);
  end

  // Trimmed write fields
  logic [ADDR_WIDTH-1:0] waddr_a;
  logic [ADDR_WIDTH-1:0] waddr_b;
  logic [DATA_WIDTH-1:0] wdata_a;
  logic [DATA_WIDTH-1:0] wdata_b;

  // Per-word enables, no bit for word 0
  logic [NUM_WORDS-1:1]  we_oh_a;
  logic [NUM_WORDS-1:1]  we_oh_b;

  // Words 1 and up, word 0 has no storage
  logic [DATA_WIDTH-1:0] mem_q [1:NUM_WORDS-1];

  logic [ADDR_WIDTH-1:0] raddr_a;
  logic [ADDR_WIDTH-1:0] raddr_b;
  logic [ADDR_WIDTH-1:0] raddr_c;

  assign waddr_a = wr_a_i.addr[ADDR_WIDTH-1:0];
  assign waddr_b = wr_b_i.addr[ADDR_WIDTH-1:0];
  assign wdata_a = wr_a_i.data[DATA_WIDTH-1:0];
  assign wdata_b = wr_b_i.data[DATA_WIDTH-1:0];

  // -------------------------------------------------------------------------
  // Write decode
  // -------------------------------------------------------------------------

  always_comb
  begin
    for (int w = 1; w < NUM_WORDS; w++)
    begin
      we_oh_a[w] = wr_a_i.we && (waddr_a == ADDR_WIDTH'(w));
      we_oh_b[w] = wr_b_i.we && (waddr_b == ADDR_WIDTH'(w));
    end
  end

  // -------------------------------------------------------------------------
  // Word update
  // -------------------------------------------------------------------------

  always_ff @(posedge clk_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int w = 1; w < NUM_WORDS; w++)
      begin
        mem_q[w] <= '0;
      end
    end
    else
    begin
      for (int w = 1; w < NUM_WORDS; w++)
      begin
        // Port B checked first, so it wins when both name this word
        if (we_oh_b[w])
        begin
          mem_q[w] <= wdata_b;
        end
        else if (we_oh_a[w])
        begin
          mem_q[w] <= wdata_a;
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // Read ports
  // -------------------------------------------------------------------------

  // Address 0 never touches the array
  function automatic logic [DATA_W_MAX-1:0] read_word(input logic [ADDR_WIDTH-1:0] raddr);
    logic [DATA_W_MAX-1:0] rdata;
    rdata = '0;
    if (raddr != '0)
    begin
      rdata[DATA_WIDTH-1:0] = mem_q[raddr];
    end
    return rdata;
  endfunction

  assign raddr_a = rd_a_i.addr[ADDR_WIDTH-1:0];
  assign raddr_b = rd_b_i.addr[ADDR_WIDTH-1:0];
  assign raddr_c = rd_c_i.addr[ADDR_WIDTH-1:0];

  // Address echoed back with the data
  always_comb
  begin
    rd_a_o.addr = rd_a_i.addr;
    rd_a_o.data = read_word(raddr_a);
    rd_b_o.addr = rd_b_i.addr;
    rd_b_o.data = read_word(raddr_b);
    rd_c_o.addr = rd_c_i.addr;
    rd_c_o.data = read_word(raddr_c);
  end

  // Word 0 reads zero on every port, whatever was written or cleared
  a_word0_zero : assert property (@(posedge clk_int) disable iff (!rst_n)
    (raddr_a != '0 || rd_a_o.data == '0) &&
    (raddr_b != '0 || rd_b_o.data == '0) &&
    (raddr_c != '0 || rd_c_o.data == '0))
    else $error("rf_storage: word 0 read back nonzero");

endmodule

`default_nettype wire

//--- rtl/rf_subsystem.sv
// Register-file subsystem top level
//   Clear FSM and pair address counter
//   Write arbiter in front of the storage
//   Read addresses packed into the read-port structs

`timescale 1ns/100ps
`default_nettype none

module rf_subsystem #(
  parameter int unsigned ADDR_WIDTH = 5,
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                          clk_int,
  input  logic                          rst_n,
  // External write ports
  input  rf_pkg::rf_wr_t                wr_a_i,
  input  rf_pkg::rf_wr_t                wr_b_i,
  // Read ports
  input  logic [rf_pkg::ADDR_W_MAX-1:0] rd_addr_a_i,
  input  logic [rf_pkg::ADDR_W_MAX-1:0] rd_addr_b_i,
  input  logic [rf_pkg::ADDR_W_MAX-1:0] rd_addr_c_i,
  output logic [rf_pkg::DATA_W_MAX-1:0] rd_data_a_o,
  output logic [rf_pkg::DATA_W_MAX-1:0] rd_data_b_o,
  output logic [rf_pkg::DATA_W_MAX-1:0] rd_data_c_o,
  // Bulk clear
  input  logic                          clear_i,
  output logic                          busy_o
);

  import rf_pkg::*;

  // Sequencer
  logic                  cnt_start;
  logic                  cnt_en;
  logic                  cnt_last;
  logic                  clearing;
  logic [ADDR_WIDTH-1:0] cnt_addr;

  // Arbitrated writes into the storage
  rf_wr_t wr_a_q;
  rf_wr_t wr_b_q;

  // Read requests and responses
  rf_rd_t rd_a_req;
  rf_rd_t rd_b_req;
  rf_rd_t rd_c_req;
  rf_rd_t rd_a_rsp;
  rf_rd_t rd_b_rsp;
  rf_rd_t rd_c_rsp;

  // -------------------------------------------------------------------------
  // Clear sequencer
  // -------------------------------------------------------------------------

  rf_clear_fsm u_clear_fsm (
    .clk_int     (clk_int),
    .rst_n       (rst_n),
    .clear_i     (clear_i),
    .cnt_last_i  (cnt_last),
    .cnt_start_o (cnt_start),
    .cnt_en_o    (cnt_en),
    .clearing_o  (clearing)
  );

  rf_addr_counter #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_addr_counter (
    .clk_int (clk_int),
    .rst_n   (rst_n),
    .start_i (cnt_start),
    .en_i    (cnt_en),
    .addr_o  (cnt_addr),
    .last_o  (cnt_last)
  );

  assign busy_o = clearing;

  // -------------------------------------------------------------------------
  // Write path and storage
  // -------------------------------------------------------------------------

  rf_write_arbiter #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_write_arbiter (
    .clearing_i (clearing),
    .cnt_addr_i (cnt_addr),
    .wr_a_i     (wr_a_i),
    .wr_b_i     (wr_b_i),
    .wr_a_o     (wr_a_q),
    .wr_b_o     (wr_b_q)
  );

  // Data field of a request is unused by the storage
  assign rd_a_req.addr = rd_addr_a_i;
  assign rd_a_req.data = '0;
  assign rd_b_req.addr = rd_addr_b_i;
  assign rd_b_req.data = '0;
  assign rd_c_req.addr = rd_addr_c_i;
  assign rd_c_req.data = '0;

  rf_storage #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_storage (
    .clk_int (clk_int),
    .rst_n   (rst_n),
    .wr_a_i  (wr_a_q),
    .wr_b_i  (wr_b_q),
    .rd_a_i  (rd_a_req),
    .rd_b_i  (rd_b_req),
    .rd_c_i  (rd_c_req),
    .rd_a_o  (rd_a_rsp),
    .rd_b_o  (rd_b_rsp),
    .rd_c_o  (rd_c_rsp)
  );

  assign rd_data_a_o = rd_a_rsp.data;
  assign rd_data_b_o = rd_b_rsp.data;
  assign rd_data_c_o = rd_c_rsp.data;

endmodule

`default_nettype wire

//--- verification/rf_subsystem_tb.sv
// Testbench for the register-file subsystem
//   Clock, reset and stimulus tasks
//   Shadow-array reference model with clear timing
//   Per-cycle compare of all read ports and busy
//   Cycle-limit timeout and result summary

`timescale 1ns/100ps
`default_nettype none

module rf_subsystem_tb;

  import rf_pkg::*;

  localparam int ADDR_WIDTH   = 5;
  localparam int NUM_WORDS    = 1 << ADDR_WIDTH;
  localparam int CLEAR_CYCLES = NUM_WORDS / 2;
  localparam int MAX_CYCLES   = 2000;

  logic                  clk_int;
  logic                  rst_n;
  rf_wr_t                wr_a_i;
  rf_wr_t                wr_b_i;
  logic [ADDR_W_MAX-1:0] rd_addr_a_i;
  logic [ADDR_W_MAX-1:0] rd_addr_b_i;
  logic [ADDR_W_MAX-1:0] rd_addr_c_i;
  logic [DATA_W_MAX-1:0] rd_data_a_o;
  logic [DATA_W_MAX-1:0] rd_data_b_o;
  logic [DATA_W_MAX-1:0] rd_data_c_o;
  logic                  clear_i;
  logic                  busy_o;

  // Reference model state
  logic [DATA_W_MAX-1:0] shadow [0:NUM_WORDS-1];
  int                    busy_cnt;

  // Bookkeeping
  int seed = 49688;
  int err_cnt;
  int err_at_start;
  int pass_tests;
  int fail_tests;
  int cycles;

  rf_subsystem DUT (
    .clk_int     (clk_int),
    .rst_n       (rst_n),
    .wr_a_i      (wr_a_i),
    .wr_b_i      (wr_b_i),
    .rd_addr_a_i (rd_addr_a_i),
    .rd_addr_b_i (rd_addr_b_i),
    .rd_addr_c_i (rd_addr_c_i),
    .rd_data_a_o (rd_data_a_o),
    .rd_data_b_o (rd_data_b_o),
    .rd_data_c_o (rd_data_c_o),
    .clear_i     (clear_i),
    .busy_o      (busy_o)
  );

  // 20 ns clock
  always #10 clk_int = ~clk_int;

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  // Register file update at one clock edge
  function automatic void rf_model_write(input rf_wr_t a, input rf_wr_t b, input logic clr);
    if (busy_cnt != 0)
    begin
      // External requests and clear pulses are lost while a clear runs
      busy_cnt--;
    end
    else if (clr)
    begin
      busy_cnt = CLEAR_CYCLES;
      for (int w = 0; w < NUM_WORDS; w++)
      begin
        shadow[w] = '0;
      end
    end
    else
    begin
      // Port A first so port B overwrites a shared word
      if (a.we && a.addr != '0)
      begin
        shadow[a.addr] = a.data;
      end
      if (b.we && b.addr != '0)
      begin
        shadow[b.addr] = b.data;
      end
    end
  endfunction

  // Inputs read here still hold the values driven before this edge
  always @(posedge clk_int)
  begin
    if (!rst_n)
    begin
      busy_cnt = 0;
      for (int w = 0; w < NUM_WORDS; w++)
      begin
        shadow[w] = '0;
      end
    end
    else
    begin
      rf_model_write(wr_a_i, wr_b_i, clear_i);
    end
  end

  // --------------------------------------------------------------------------
  // Compare tasks and per-cycle compare
  // --------------------------------------------------------------------------

  task automatic check_data(input string name, input logic [DATA_W_MAX-1:0] exp,
                            input logic [DATA_W_MAX-1:0] act);
    if (act !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_busy(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // Inputs and outputs are settled at the falling edge
  always @(negedge clk_int)
  begin
    if (rst_n)
    begin
      check_busy("busy_o", busy_cnt != 0, busy_o);
      // Word contents during a clear are not modelled
      if (busy_cnt == 0)
      begin
        check_data("rd_data_a_o", shadow[rd_addr_a_i], rd_data_a_o);
        check_data("rd_data_b_o", shadow[rd_addr_b_i], rd_data_b_o);
        check_data("rd_data_c_o", shadow[rd_addr_c_i], rd_data_c_o);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------

  function automatic rf_wr_t make_wr(input logic we, input logic [ADDR_W_MAX-1:0] addr,
                                     input logic [DATA_W_MAX-1:0] data);
    rf_wr_t req;
    req.we   = we;
    req.addr = addr;
    req.data = data;
    return req;
  endfunction

  function automatic logic [ADDR_W_MAX-1:0] rand_addr();
    return ADDR_W_MAX'($random(seed));
  endfunction

  function automatic logic [DATA_W_MAX-1:0] rand_data();
    return DATA_W_MAX'($random(seed));
  endfunction

  task automatic drive_idle();
    @(posedge clk_int);
    wr_a_i  <= '0;
    wr_b_i  <= '0;
    clear_i <= 1'b0;
  endtask

  // Every word on every port
  task automatic sweep_reads();
    for (int i = 0; i < NUM_WORDS; i++)
    begin
      @(posedge clk_int);
      rd_addr_a_i <= ADDR_W_MAX'(i);
      rd_addr_b_i <= ADDR_W_MAX'(NUM_WORDS - 1 - i);
      rd_addr_c_i <= ADDR_W_MAX'((i + NUM_WORDS / 2) % NUM_WORDS);
    end
    // The extra edge lets the last read be compared
    @(posedge clk_int);
  endtask

  // Clear pulse followed by a wait on busy_o with optional traffic while it is high
  task automatic run_clear(input bit second_clear, input bit busy_writes);
    int n;
    n = 0;
    @(posedge clk_int);
    clear_i <= 1'b1;
    wr_a_i  <= '0;
    wr_b_i  <= '0;
    @(posedge clk_int);
    clear_i <= 1'b0;
    @(negedge clk_int);
    while (busy_o)
    begin
      @(posedge clk_int);
      clear_i <= second_clear && (n == 4);
      // Only requests that the DUT samples while still busy
      if (busy_writes && n < CLEAR_CYCLES - 1)
      begin
        wr_a_i <= make_wr(1'b1, rand_addr(), rand_data());
        wr_b_i <= make_wr(1'b1, rand_addr(), rand_data());
      end
      else
      begin
        wr_a_i <= '0;
        wr_b_i <= '0;
      end
      n++;
      @(negedge clk_int);
    end
    drive_idle();
  endtask

  task automatic begin_test();
    err_at_start = err_cnt;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == err_at_start)
    begin
      pass_tests++;
      $display("Test %s: PASS", name);
    end
    else
    begin
      fail_tests++;
      $display("Test %s: FAIL with %0d errors", name, err_cnt - err_at_start);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial
  begin
    rf_wr_t                a;
    rf_wr_t                b;
    logic [ADDR_W_MAX-1:0] prev_a;
    logic [ADDR_W_MAX-1:0] prev_b;
    logic [ADDR_W_MAX-1:0] k;
    logic [DATA_W_MAX-1:0] db;

    clk_int     = 1'b0;
    rst_n       = 1'b0;
    wr_a_i      = '0;
    wr_b_i      = '0;
    rd_addr_a_i = '0;
    rd_addr_b_i = '0;
    rd_addr_c_i = '0;
    clear_i     = 1'b0;
    err_cnt     = 0;
    pass_tests  = 0;
    fail_tests  = 0;
    repeat (4) @(posedge clk_int);
    rst_n <= 1'b1;

    begin_test();
    sweep_reads();
    end_test("1 reset contents");

    // Read each port's last write address one cycle later
    begin_test();
    prev_a = '0;
    prev_b = '0;
    for (int i = 0; i < 120; i++)
    begin
      a = make_wr((rand_data() & 32'h3) != 0, rand_addr(), rand_data());
      b = make_wr((rand_data() & 32'h3) != 0, rand_addr(), rand_data());
      @(posedge clk_int);
      wr_a_i      <= a;
      wr_b_i      <= b;
      rd_addr_a_i <= prev_a;
      rd_addr_b_i <= prev_b;
      rd_addr_c_i <= rand_addr();
      prev_a = a.addr;
      prev_b = b.addr;
    end
    drive_idle();
    end_test("2 random writes");

    begin_test();
    @(posedge clk_int);
    wr_a_i      <= make_wr(1'b1, '0, 32'hdead_beef);
    rd_addr_a_i <= '0;
    rd_addr_b_i <= '0;
    rd_addr_c_i <= '0;
    @(posedge clk_int);
    wr_a_i <= '0;
    wr_b_i <= make_wr(1'b1, '0, 32'hcafe_f00d);
    @(posedge clk_int);
    wr_a_i <= make_wr(1'b1, '0, 32'h1234_5678);
    wr_b_i <= make_wr(1'b1, '0, 32'h8765_4321);
    drive_idle();
    drive_idle();
    end_test("3 word 0 writes");

    // Same word on both ports and then two different words
    begin_test();
    k  = rand_addr() | ADDR_W_MAX'(1);
    db = rand_data();
    @(posedge clk_int);
    wr_a_i <= make_wr(1'b1, k, ~db);
    wr_b_i <= make_wr(1'b1, k, db);
    drive_idle();
    rd_addr_a_i <= k;
    rd_addr_b_i <= k;
    rd_addr_c_i <= k;
    @(negedge clk_int);
    check_data("rd_data_a_o", db, rd_data_a_o);
    k = (rand_addr() & ADDR_W_MAX'(15)) | ADDR_W_MAX'(1);
    @(posedge clk_int);
    wr_a_i <= make_wr(1'b1, k, rand_data());
    wr_b_i <= make_wr(1'b1, k ^ ADDR_W_MAX'(16), rand_data());
    drive_idle();
    rd_addr_a_i <= k;
    rd_addr_b_i <= k ^ ADDR_W_MAX'(16);
    rd_addr_c_i <= k;
    drive_idle();
    end_test("4 dual-port writes");

    begin_test();
    run_clear(1'b1, 1'b0);
    sweep_reads();
    end_test("5 bulk clear");

    // Refill some words so the next clear has work to do
    begin_test();
    for (int i = 0; i < 16; i++)
    begin
      @(posedge clk_int);
      wr_a_i <= make_wr(1'b1, rand_addr(), rand_data());
      wr_b_i <= make_wr(1'b1, rand_addr(), rand_data());
    end
    drive_idle();
    run_clear(1'b0, 1'b1);
    sweep_reads();
    end_test("6 writes during clear");

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             pass_tests, fail_tests, err_cnt);
    if (fail_tests == 0 && err_cnt == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Cycle limit at several times the length of the whole sequence
  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk_int);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- rf_subsystem.f
rtl/rf_pkg.sv
rtl/rf_addr_counter.sv
rtl/rf_clear_fsm.sv
rtl/rf_write_arbiter.sv
rtl/rf_storage.sv
rtl/rf_subsystem.sv
verification/rf_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the register-file testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module rf_subsystem_tb \
  -f rf_subsystem.f \
  -o rf_sim

out=$(./obj_dir/rf_sim)
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
else
  exit 1
fi
